/* src/grid_arb_pkg.sv */
package grid_arb_pkg;

  // Requester grid geometry
  localparam int GRID_ROWS   = 2;                      // Requester rows
  localparam int GRID_COLS   = 4;                      // Requesters per row
  localparam int NUM_CLIENTS = GRID_ROWS * GRID_COLS;  // Client = row * GRID_COLS + col
  localparam int ROW_ADD_W   = 1;                      // Row index width
  localparam int COL_ADD_W   = 2;                      // Column index width

  // Shared RAM geometry, 64 x 16
  localparam int MEM_ADDR_W  = 6;
  localparam int MEM_DATA_W  = 16;

  typedef logic [GRID_ROWS-1:0]   row_vec_t;     // One bit per row
  typedef logic [GRID_COLS-1:0]   col_vec_t;     // One bit per column
  typedef logic [NUM_CLIENTS-1:0] client_vec_t;  // One bit per requester
  typedef logic [ROW_ADD_W-1:0]   row_idx_t;
  typedef logic [COL_ADD_W-1:0]   col_idx_t;
  typedef logic [MEM_ADDR_W-1:0]  mem_addr_t;
  typedef logic [MEM_DATA_W-1:0]  mem_data_t;

  // Row selection FSM states
  typedef enum logic [1:0] {
    ROW_IDLE,    // No row has requests
    ROW_SERVE,   // Column arbiter enabled on the selected row
    ROW_SWITCH   // One dead cycle so the column mask reopens
  } row_state_e;

  // One-hot of the lowest set bit, zero when nothing is set
  function automatic col_vec_t lowest_set(input col_vec_t vec);
    col_vec_t neg;
    neg = ~vec + col_vec_t'(1);  // Two's complement keeps only the lowest one
    return vec & neg;
  endfunction

endpackage

/* src/column_arbiter.sv */
`timescale 1ns/1ps

// Masked round-robin over the four columns of the selected row.
// A grant pushes the mask above the granted column, so each column
// gets at most one grant per pass; when the pass runs dry the mask
// reopens and the group release tells the row arbiter to move on.
module column_arbiter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    enable_i,       // Row arbiter is serving this row
  input  grid_arb_pkg::col_vec_t  req_i,          // Request bits of the selected row
  output grid_arb_pkg::col_vec_t  gnt_o,          // Registered one-hot grant
  output grid_arb_pkg::col_idx_t  col_add_o,      // Index of the granted column
  output logic                    grp_release_o   // Mask exhausted, pulse for one cycle
);

  grid_arb_pkg::col_vec_t mask_q;     // Columns still eligible in this pass
  grid_arb_pkg::col_vec_t mask_req;   // Requests passing the mask
  grid_arb_pkg::col_vec_t gnt_next;   // Combinational pick
  grid_arb_pkg::col_vec_t mask_next;  // Mask after this pick
  logic                   exhausted;  // Requests present but all masked off

  assign mask_req = req_i & mask_q;
  assign gnt_next = grid_arb_pkg::lowest_set(mask_req);  // Lowest eligible column wins

  // Keep only columns above the winner; no winner reopens the whole row
  always_comb
  begin
    if (gnt_next == '0)
    begin
      mask_next = '1;
    end
    else
    begin
      mask_next = ~((gnt_next << 1) - grid_arb_pkg::col_vec_t'(1));
    end
  end

  assign exhausted = enable_i && (|req_i) && (mask_req == '0);

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      mask_q <= '1;    // Everyone eligible
      gnt_o  <= '0;
    end
    else if (enable_i)
    begin
      mask_q <= mask_next;
      gnt_o  <= gnt_next;
    end
    else
    begin
      mask_q <= '1;    // Fresh pass for the next row
      gnt_o  <= '0;    // No grants while disabled
    end
  end

  // Registered release so the row arbiter sees a clean pulse
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      grp_release_o <= 1'b0;
    end
    else
    begin
      grp_release_o <= exhausted;
    end
  end

  // Encode the registered grant, zero when idle
  always_comb
  begin
    col_add_o = '0;
    for (int c = 0; c < grid_arb_pkg::GRID_COLS; c++)
    begin
      if (gnt_o[c])
      begin
        col_add_o = grid_arb_pkg::col_idx_t'(c);  // One-hot, so a single hit
      end
    end
  end

endmodule

/* src/row_arbiter.sv */
`timescale 1ns/1ps

module row_arbiter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  grid_arb_pkg::row_vec_t  row_req_i,      // OR of each row's requests
  input  logic                    grp_release_i,  // Column group done with its pass
  output grid_arb_pkg::row_idx_t  row_sel_o,      // Row currently owned
  output logic                    col_enable_o    // Lets the column arbiter grant
);

  grid_arb_pkg::row_state_e state_q, state_d;
  grid_arb_pkg::row_idx_t   row_q, row_d;
  grid_arb_pkg::row_idx_t   next_row;    // Next requesting row after row_q
  logic                     next_found;  // Some row is requesting
  grid_arb_pkg::row_idx_t   cand;        // Loop candidate

  // Round-robin search starting just after the current row,
  // the current row itself is checked last
  always_comb
  begin
    next_row   = row_q;
    next_found = 1'b0;
    cand       = row_q;
    for (int i = 1; i <= grid_arb_pkg::GRID_ROWS; i++)
    begin
      cand = grid_arb_pkg::row_idx_t'((int'(row_q) + i) % grid_arb_pkg::GRID_ROWS);
      if (!next_found && row_req_i[cand])
      begin
        next_row   = cand;
        next_found = 1'b1;
      end
    end
  end

  always_comb
  begin
    state_d = state_q;
    row_d   = row_q;   // Row only moves on entry to SERVE
    case (state_q)
      grid_arb_pkg::ROW_IDLE:
      begin
        if (next_found)
        begin
          state_d = grid_arb_pkg::ROW_SERVE;
          row_d   = next_row;
        end
      end
      grid_arb_pkg::ROW_SERVE:
      begin
        if (grp_release_i || !row_req_i[row_q])
        begin
          state_d = grid_arb_pkg::ROW_SWITCH;  // Pass finished or row emptied
        end
      end
      grid_arb_pkg::ROW_SWITCH:
      begin
        if (next_found)
        begin
          state_d = grid_arb_pkg::ROW_SERVE;
          row_d   = next_row;
        end
        else
        begin
          state_d = grid_arb_pkg::ROW_IDLE;
        end
      end
      default: state_d = grid_arb_pkg::ROW_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      state_q <= grid_arb_pkg::ROW_IDLE;
      row_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      row_q   <= row_d;
    end
  end

  assign row_sel_o = row_q;
  // Release drops the enable at once so the reopened mask grants nothing more
  assign col_enable_o = (state_q == grid_arb_pkg::ROW_SERVE) && !grp_release_i;

endmodule

/* src/mem_request_mux.sv */
`timescale 1ns/1ps

module mem_request_mux (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  grid_arb_pkg::row_idx_t                               row_sel_i,
  input  grid_arb_pkg::col_vec_t                               col_gnt_i,
  input  grid_arb_pkg::col_idx_t                               col_add_i,
  input  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_ADDR_W-1:0] addr_i,
  input  grid_arb_pkg::client_vec_t                            we_i,
  input  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_DATA_W-1:0] wdata_i,
  output logic                                                 mem_en_o,
  output logic                                                 mem_we_o,
  output grid_arb_pkg::mem_addr_t                              mem_addr_o,
  output grid_arb_pkg::mem_data_t                              mem_wdata_o,
  output grid_arb_pkg::client_vec_t                            gnt_o,
  output grid_arb_pkg::client_vec_t                            rvalid_o
);

  localparam int CLIENT_W = grid_arb_pkg::ROW_ADD_W + grid_arb_pkg::COL_ADD_W;

  logic [CLIENT_W-1:0]       client_idx;  // row * GRID_COLS + col
  grid_arb_pkg::client_vec_t rd_pend_q;   // Reads granted last cycle

  assign client_idx = {row_sel_i, col_add_i};  // GRID_COLS is a power of two

  // Drop the column grant into the selected row's slice
  always_comb
  begin
    gnt_o = '0;
    for (int r = 0; r < grid_arb_pkg::GRID_ROWS; r++)
    begin
      if (row_sel_i == grid_arb_pkg::row_idx_t'(r))
      begin
        gnt_o[r*grid_arb_pkg::GRID_COLS +: grid_arb_pkg::GRID_COLS] = col_gnt_i;
      end
    end
  end

  // RAM access happens in the grant cycle itself
  assign mem_en_o    = |col_gnt_i;
  assign mem_we_o    = mem_en_o && we_i[client_idx];
  assign mem_addr_o  = addr_i[client_idx*grid_arb_pkg::MEM_ADDR_W +: grid_arb_pkg::MEM_ADDR_W];
  assign mem_wdata_o = wdata_i[client_idx*grid_arb_pkg::MEM_DATA_W +: grid_arb_pkg::MEM_DATA_W];

  // Remember the reader; RAM data lands one cycle after the grant
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      rd_pend_q <= '0;
    end
    else
    begin
      rd_pend_q <= gnt_o & ~we_i;  // Writes get no read-valid
    end
  end

  assign rvalid_o = rd_pend_q;  // Lines up with the RAM output register

endmodule

/* src/shared_mem.sv */
`timescale 1ns/1ps

// Single-port 64x16 RAM, one access per cycle.
// Read data is registered, so it shows up the cycle after the access.
module shared_mem (
  input  logic                    clk_i,
  input  logic                    en_i,     // Access strobe
  input  logic                    we_i,     // 1 = write, 0 = read
  input  grid_arb_pkg::mem_addr_t addr_i,
  input  grid_arb_pkg::mem_data_t wdata_i,
  output grid_arb_pkg::mem_data_t rdata_o   // Valid one cycle after a read
);

  localparam int DEPTH = 2 ** grid_arb_pkg::MEM_ADDR_W;  // 64 words

  grid_arb_pkg::mem_data_t mem_q [DEPTH];  // Storage array

  always_ff @(posedge clk_i)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        mem_q[addr_i] <= wdata_i;  // Write committed at end of grant cycle
      end
      else
      begin
        rdata_o <= mem_q[addr_i];  // Registered read
      end
    end
  end

endmodule

/* src/grid_mem_top.sv */
`timescale 1ns/1ps

module grid_mem_top (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  grid_arb_pkg::client_vec_t                            req_i,    // Held until granted
  input  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_ADDR_W-1:0] addr_i,
  input  grid_arb_pkg::client_vec_t                            we_i,
  input  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_DATA_W-1:0] wdata_i,
  output grid_arb_pkg::client_vec_t                            gnt_o,    // One-hot pulse
  output grid_arb_pkg::client_vec_t                            rvalid_o, // One-hot pulse
  output grid_arb_pkg::mem_data_t                              rdata_o   // Qualified by rvalid_o
);

  grid_arb_pkg::row_vec_t  row_req;      // Any request per row
  grid_arb_pkg::row_idx_t  row_sel;      // Row owned by the column arbiter
  logic                    col_enable;
  grid_arb_pkg::col_vec_t  col_req;      // Requests of the selected row
  grid_arb_pkg::col_vec_t  col_gnt;
  grid_arb_pkg::col_idx_t  col_add;
  logic                    grp_release;
  logic                    mem_en;
  logic                    mem_we;
  grid_arb_pkg::mem_addr_t mem_addr;
  grid_arb_pkg::mem_data_t mem_wdata;
  grid_arb_pkg::mem_data_t mem_rdata;

  // Collapse each row's requests for the row arbiter
  always_comb
  begin
    for (int r = 0; r < grid_arb_pkg::GRID_ROWS; r++)
    begin
      row_req[r] = |req_i[r*grid_arb_pkg::GRID_COLS +: grid_arb_pkg::GRID_COLS];
    end
  end

  assign col_req = req_i[row_sel*grid_arb_pkg::GRID_COLS +: grid_arb_pkg::GRID_COLS];

  row_arbiter row_arbiter_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .row_req_i     (row_req),
    .grp_release_i (grp_release),
    .row_sel_o     (row_sel),
    .col_enable_o  (col_enable)
  );

  column_arbiter column_arbiter_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .enable_i      (col_enable),
    .req_i         (col_req),
    .gnt_o         (col_gnt),
    .col_add_o     (col_add),
    .grp_release_o (grp_release)
  );

  mem_request_mux mem_request_mux_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .row_sel_i   (row_sel),
    .col_gnt_i   (col_gnt),
    .col_add_i   (col_add),
    .addr_i      (addr_i),
    .we_i        (we_i),
    .wdata_i     (wdata_i),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .gnt_o       (gnt_o),
    .rvalid_o    (rvalid_o)
  );

  shared_mem shared_mem_inst (
    .clk_i   (clk_i),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  assign rdata_o = mem_rdata;  // Shared read bus

endmodule

/* test/grid_mem_assert.sv */
`timescale 1ns/1ps

module grid_mem_assert (
  input  logic                                                 clk_i,
  input  logic                                                 reset_i,
  input  grid_arb_pkg::client_vec_t                            req_i,
  input  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_ADDR_W-1:0] addr_i,
  input  grid_arb_pkg::client_vec_t                            we_i,
  input  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_DATA_W-1:0] wdata_i,
  input  grid_arb_pkg::client_vec_t                            gnt_o,
  input  grid_arb_pkg::client_vec_t                            rvalid_o,
  input  grid_arb_pkg::mem_data_t                              rdata_o
);

  localparam int WAIT_LIMIT = grid_arb_pkg::NUM_CLIENTS + 2 * grid_arb_pkg::GRID_ROWS + 4;
  localparam int DEPTH      = 2 ** grid_arb_pkg::MEM_ADDR_W;

  int                        err_cnt = 0;     // Read by the testbench monitor
  grid_arb_pkg::client_vec_t req_q;           // Requests seen one cycle back
  grid_arb_pkg::client_vec_t rd_gnt_q;        // Read grants one cycle back
  grid_arb_pkg::mem_data_t   shadow_q [DEPTH]; // Reference copy of the RAM
  logic [DEPTH-1:0]          known_q;         // Word written at least once
  grid_arb_pkg::mem_data_t   exp_q;           // Expected data for the next rvalid
  logic                      exp_known_q;
  grid_arb_pkg::mem_addr_t   g_addr;          // Granted client's access
  grid_arb_pkg::mem_data_t   g_wdata;
  logic                      g_we;
  grid_arb_pkg::client_vec_t seen_q [grid_arb_pkg::NUM_CLIENTS];  // Grants while waiting
  int                        wait_q [grid_arb_pkg::NUM_CLIENTS];

  always_comb
  begin
    g_addr  = '0;
    g_wdata = '0;
    g_we    = 1'b0;
    for (int k = 0; k < grid_arb_pkg::NUM_CLIENTS; k++)
    begin
      if (gnt_o[k])
      begin
        g_addr  = addr_i[k*grid_arb_pkg::MEM_ADDR_W +: grid_arb_pkg::MEM_ADDR_W];
        g_wdata = wdata_i[k*grid_arb_pkg::MEM_DATA_W +: grid_arb_pkg::MEM_DATA_W];
        g_we    = we_i[k];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (!reset_i && (|gnt_o) && g_we)
    begin
      shadow_q[g_addr] <= g_wdata;  // Mirrors the RAM commit
    end
  end

  always_ff @(posedge clk_i or posedge reset_i)
  begin
    if (reset_i)
    begin
      req_q       <= '0;
      rd_gnt_q    <= '0;
      known_q     <= '0;
      exp_q       <= '0;
      exp_known_q <= 1'b0;
    end
    else
    begin
      req_q    <= req_i;
      rd_gnt_q <= gnt_o & ~we_i;
      if ((|gnt_o) && g_we)
      begin
        known_q[g_addr] <= 1'b1;
      end
      exp_q       <= shadow_q[g_addr];  // Old contents, as the RAM reads them
      exp_known_q <= (|gnt_o) && !g_we && known_q[g_addr];
    end
  end

  // Per-client wait tracking that clears on a grant or a dropped request
  always_ff @(posedge clk_i or posedge reset_i)
  begin
    for (int k = 0; k < grid_arb_pkg::NUM_CLIENTS; k++)
    begin
      if (reset_i || gnt_o[k] || !req_i[k])
      begin
        seen_q[k] <= '0;
        wait_q[k] <= 0;
      end
      else
      begin
        seen_q[k] <= seen_q[k] | gnt_o;
        wait_q[k] <= wait_q[k] + 1;
      end
    end
  end

  reset_quiet: assert property (@(posedge clk_i) reset_i |-> (gnt_o == '0 && rvalid_o == '0))
    else
    begin
      err_cnt = err_cnt + 1;
      $error("[ERROR] reset_state expected 0 actual gnt %b rvalid %b", gnt_o, rvalid_o);
    end

  // No grant can be registered in the first two cycles out of reset
  after_reset: assert property (@(posedge clk_i)
    (!reset_i && $past(reset_i, 2)) |-> (gnt_o == '0 && rvalid_o == '0))
    else
    begin
      err_cnt = err_cnt + 1;
      $error("[ERROR] after_reset expected 0 actual gnt %b rvalid %b", gnt_o, rvalid_o);
    end

  gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o))
    else
    begin
      err_cnt = err_cnt + 1;
      $error("[ERROR] gnt_onehot expected one-hot actual %b", gnt_o);
    end

  gnt_legal: assert property (@(posedge clk_i) disable iff (reset_i) (gnt_o & ~req_q) == '0)
    else
    begin
      err_cnt = err_cnt + 1;
      $error("[ERROR] gnt_legal expected %b actual %b", gnt_o & req_q, gnt_o);
    end

  rd_latency: assert property (@(posedge clk_i) disable iff (reset_i) rvalid_o == rd_gnt_q)
    else
    begin
      err_cnt = err_cnt + 1;
      $error("[ERROR] read_latency expected %b actual %b", rd_gnt_q, rvalid_o);
    end

  rd_data: assert property (@(posedge clk_i) disable iff (reset_i)
                            ((|rvalid_o) && exp_known_q) |-> rdata_o == exp_q)
    else
    begin
      err_cnt = err_cnt + 1;
      $error("[ERROR] read_data expected %h actual %h", exp_q, rdata_o);
    end

  for (genvar k = 0; k < grid_arb_pkg::NUM_CLIENTS; k++)
  begin : g_client
    // Nobody is served twice while this client waits
    fair: assert property (@(posedge clk_i) disable iff (reset_i) (seen_q[k] & gnt_o) == '0)
      else
      begin
        err_cnt = err_cnt + 1;
        $error("Client %0d waited while %b was granted a second time", k, gnt_o);
      end

    starve: assert property (@(posedge clk_i) disable iff (reset_i) wait_q[k] <= WAIT_LIMIT)
      else
      begin
        err_cnt = err_cnt + 1;
        $error("[ERROR] wait_limit client %0d expected <= %0d actual %0d",
               k, WAIT_LIMIT, wait_q[k]);
      end
  end

endmodule

/* test/grid_mem_tb.sv */
`timescale 1ns/1ps

module grid_mem_tb;

  localparam int MAX_CYCLES = 4000;  // 6 phases of up to 400 cycles plus margin

  logic                                                           clk_i;
  logic                                                           reset_i;
  grid_arb_pkg::client_vec_t                                      req_i;
  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_ADDR_W-1:0] addr_i;
  grid_arb_pkg::client_vec_t                                      we_i;
  logic [grid_arb_pkg::NUM_CLIENTS*grid_arb_pkg::MEM_DATA_W-1:0] wdata_i;
  grid_arb_pkg::client_vec_t                                      gnt_o;
  grid_arb_pkg::client_vec_t                                      rvalid_o;
  grid_arb_pkg::mem_data_t                                        rdata_o;

  logic [15:0] lfsr_q;     // Random source
  int          cycle_cnt;

  grid_mem_top grid_mem_top_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .addr_i   (addr_i),
    .we_i     (we_i),
    .wdata_i  (wdata_i),
    .gnt_o    (gnt_o),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o)
  );

  bind grid_mem_top grid_mem_assert grid_mem_assert_inst (.*);

  always #2 clk_i = ~clk_i;  // 4 ns period

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[14:0], lfsr_q[0]};
    end
  endtask

  // Fresh access for an idle client
  task automatic load_client(input int k, input int mode);
    logic [15:0] bits;
    take_bits(4, bits);
    addr_i[k*grid_arb_pkg::MEM_ADDR_W +: grid_arb_pkg::MEM_ADDR_W] = {2'b00, bits[3:0]};  // Reads hit writes
    take_bits(2, bits);
    we_i[k] = (mode == 3) ? (bits[1] & bits[0]) : bits[0];  // Mode 3 is read heavy
    take_bits(16, bits);
    wdata_i[k*grid_arb_pkg::MEM_DATA_W +: grid_arb_pkg::MEM_DATA_W] = bits;
    req_i[k] = 1'b1;
  endtask

  // Mode 0 drives a lone row-1 client, 1 keeps all busy, 2 and 3 are random, 4 drains
  task automatic run_phase(input int cycles, input int mode);
    grid_arb_pkg::client_vec_t granted;
    grid_arb_pkg::client_vec_t dropped;
    logic [15:0]               pick;
    logic                      raise;
    repeat (cycles)
    begin
      @(negedge clk_i);
      granted = gnt_o;           // Stable mid-cycle
      @(posedge clk_i);
      #1;
      dropped = req_i & granted;
      req_i   = req_i & ~granted;  // Drop in the cycle after the grant
      for (int k = 0; k < grid_arb_pkg::NUM_CLIENTS; k++)
      begin
        raise = 1'b0;
        if (!req_i[k] && !dropped[k])
        begin
          case (mode)
            0: raise = (k == 5);
            1: raise = 1'b1;
            2, 3:
            begin
              take_bits(1, pick);
              raise = pick[0];
            end
            default: raise = 1'b0;
          endcase
        end
        if (raise)
        begin
          load_client(k, mode);
        end
      end
    end
  endtask

  // Idle the stimulus until every held request has been granted
  task automatic drain_requests();
    while (req_i != '0)
    begin
      run_phase(1, 4);
    end
  endtask

  initial
  begin
    clk_i     = 1'b0;
    reset_i   = 1'b0;
    req_i     = '0;
    addr_i    = '0;
    we_i      = '0;
    wdata_i   = '0;
    lfsr_q    = 16'd33085;
    cycle_cnt = 0;
    #1 reset_i = 1'b1;   // Clean edge ahead of the first clock
    repeat (4) @(posedge clk_i);
    #1;
    for (int k = 0; k < grid_arb_pkg::NUM_CLIENTS; k++)
    begin
      load_client(k, 2);  // Requests held through reset
    end
    repeat (4) @(posedge clk_i);
    #1 reset_i = 1'b0;
    drain_requests();    // Serve what was held through reset
    run_phase(20, 4);    // Idle
    run_phase(200, 0);   // Lone requester in row 1
    run_phase(400, 1);   // Full load, round-robin order
    run_phase(400, 2);   // Random mix
    run_phase(400, 3);   // Random mix, mostly reads
    drain_requests();
    run_phase(4, 4);     // Let the last read-valid land
    @(posedge clk_i);
    #1;                  // Past the assertion updates of this edge
    if (grid_mem_top_inst.grid_mem_assert_inst.err_cnt == 0)
    begin
      $display("PASS: all tests");
      $finish;
    end
    else
    begin
      $display("FAIL: see errors above");
      $fatal(1, "Assertion failures seen");
    end
  end

  // Stop at the first assertion failure or when the cycle budget runs out
  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (grid_mem_top_inst.grid_mem_assert_inst.err_cnt != 0)
    begin
      $display("FAIL: see errors above");
      $fatal(1, "Stopping after the first assertion failure");
    end
    else if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "Cycle limit reached");
    end
  end

endmodule

/* verilog.f */
src/grid_arb_pkg.sv
src/column_arbiter.sv
src/row_arbiter.sv
src/mem_request_mux.sv
src/shared_mem.sv
src/grid_mem_top.sv
test/grid_mem_assert.sv
test/grid_mem_tb.sv

/* Makefile */
# Verilator build and run for the grid memory testbench

TOP       ?= grid_mem_tb
SIM_DIR   ?= sim_build
VERILATOR ?= verilator
FILE_LIST ?= verilog.f
PASS_MSG  := PASS: all tests

VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check for the pass message"
	@echo "  clean  remove $(SIM_DIR)"
	@echo "  help   show this list"
	@echo "Variables: TOP=$(TOP) SIM_DIR=$(SIM_DIR) VERILATOR=$(VERILATOR)"

$(SIM_DIR)/V$(TOP): $(FILE_LIST) $(wildcard src/*.sv) $(wildcard test/*.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) \
		--Mdir $(SIM_DIR) -o V$(TOP)

test: $(SIM_DIR)/V$(TOP)
	@out="$$($(SIM_DIR)/V$(TOP) +verilator+error+limit+100 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qx "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(SIM_DIR)
